// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_usb_rx
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "FAIL: no pass line in $(LOG)"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
logic/usb_pkg.sv
logic/rx_pkg.sv
logic/usb_line_sync.sv
logic/usb_bit_unstuff.sv
logic/usb_byte_shift.sv
logic/usb_packet_fsm.sv
logic/rx_fifo.sv
logic/usb_rx.sv
sim/tb_usb_rx.sv

// File: logic/rx_fifo.sv
`timescale 1ns/1ps

module rx_fifo #(
    parameter int depth = rx_pkg::fifo_depth
) (
    input  logic           tb_clk,
    input  logic           tb_n_rst,
    input  logic           store,
    input  usb_pkg::byte_t store_data,
    input  logic           r_enable,
    output usb_pkg::byte_t r_data,
    output logic           empty,
    output logic           full
);
    import usb_pkg::*;

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = ptr_w + 1;

    byte_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_write;
    logic             do_read;

    assign do_write = store && !full;
    assign do_read  = r_enable && !empty;
    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(depth));
    // first word falls through
    assign r_data   = mem[rd_ptr];

    always_ff @(posedge tb_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= store_data;
        end
    end

    // pointers wrap at a power of two depth
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/rx_pkg.sv
package rx_pkg;

    // bit timing, in clocks
    localparam int bit_clks     = 8;
    localparam int sample_point = 4;

    // payload buffer sizing
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

endpackage

// File: logic/usb_bit_unstuff.sv
`timescale 1ns/1ps

module usb_bit_unstuff (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic bit_strobe,
    input  logic line_bit,
    input  logic eop,
    input  logic active,
    output logic data_strobe,
    output logic data_bit,
    output logic stuff_error,
    output logic eop_out,
    output logic active_out
);
    import usb_pkg::*;

    localparam int ones_w = $clog2(stuff_limit + 1);

    logic [ones_w-1:0] ones;
    logic              stuff_due;

    // next bit is a stuffed zero
    assign stuff_due = (ones == ones_w'(stuff_limit));

    // framing passes straight on
    assign eop_out    = eop;
    assign active_out = active;

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            ones        <= '0;
            data_strobe <= 1'b0;
            data_bit    <= 1'b0;
            stuff_error <= 1'b0;
        end else begin
            data_strobe <= 1'b0;
            stuff_error <= 1'b0;
            if (!active) begin
                ones <= '0;
            end else if (bit_strobe) begin
                if (stuff_due) begin
                    // swallow it, a one here is a violation
                    ones        <= '0;
                    stuff_error <= line_bit;
                end else begin
                    data_strobe <= 1'b1;
                    data_bit    <= line_bit;
                    ones        <= line_bit ? ones + 1'b1 : '0;
                end
            end
        end
    end

endmodule

// File: logic/usb_byte_shift.sv
`timescale 1ns/1ps

module usb_byte_shift (
    input  logic           tb_clk,
    input  logic           tb_n_rst,
    input  logic           data_strobe,
    input  logic           data_bit,
    input  logic           active,
    output logic           byte_strobe,
    output usb_pkg::byte_t rx_byte,
    output logic           byte_pending
);
    import usb_pkg::*;

    localparam int cnt_w = $clog2($bits(byte_t));

    logic [cnt_w-1:0] bit_cnt;
    byte_t            shreg;

    // full byte sits in the shifter until the next bit
    assign rx_byte      = shreg;
    assign byte_pending = (bit_cnt != '0);

    // lsb arrives first, shift in from the top
    always_ff @(posedge tb_clk) begin
        if (data_strobe) begin
            shreg <= {data_bit, shreg[7:1]};
        end
    end

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            bit_cnt     <= '0;
            byte_strobe <= 1'b0;
        end else begin
            byte_strobe <= 1'b0;
            if (!active) begin
                bit_cnt <= '0;
            end else if (data_strobe) begin
                // counter wraps to zero on the eighth bit
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == '1) begin
                    byte_strobe <= 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/usb_line_sync.sv
`timescale 1ns/1ps

module usb_line_sync (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic d_plus,
    input  logic d_minus,
    output logic bit_strobe,
    output logic line_bit,
    output logic eop,
    output logic active
);
    import rx_pkg::*;

    localparam int cnt_w = $clog2(bit_clks);

    typedef enum logic [1:0] {
        ln_idle,
        ln_active,
        ln_wait_j
    } line_state_t;

    line_state_t      state;
    logic             dp_meta;
    logic             dm_meta;
    logic             dp_sync;
    logic             dm_sync;
    logic             dp_last;
    logic             dm_last;
    logic             prev_level;
    logic [cnt_w-1:0] bit_cnt;
    logic             line_edge;
    logic             line_j;
    logic             line_k;
    logic             se0;
    logic             sample;

    assign line_edge = (dp_sync != dp_last) || (dm_sync != dm_last);
    assign line_j    = dp_sync && !dm_sync;
    assign line_k    = !dp_sync && dm_sync;
    assign se0       = !dp_sync && !dm_sync;
    assign sample    = (bit_cnt == cnt_w'(sample_point - 1));
    assign active    = (state == ln_active);

    // ********************
    // synchronizer, idles at J
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            dp_meta <= 1'b1;
            dm_meta <= 1'b0;
            dp_sync <= 1'b1;
            dm_sync <= 1'b0;
            dp_last <= 1'b1;
            dm_last <= 1'b0;
        end else begin
            dp_meta <= d_plus;
            dm_meta <= d_minus;
            dp_sync <= dp_meta;
            dm_sync <= dm_meta;
            dp_last <= dp_sync;
            dm_last <= dm_sync;
        end
    end

    // bit counter, realigned by every line edge
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            bit_cnt <= '0;
        end else if (line_edge) begin
            bit_cnt <= cnt_w'(1);
        end else if (bit_cnt == cnt_w'(bit_clks - 1)) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // ********************
    // nrzi decode and eop
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            state      <= ln_idle;
            bit_strobe <= 1'b0;
            line_bit   <= 1'b1;
            eop        <= 1'b0;
            prev_level <= 1'b1;
        end else begin
            bit_strobe <= 1'b0;
            eop        <= 1'b0;
            case (state)
                ln_idle: begin
                    prev_level <= 1'b1;
                    // first K after idle starts the packet
                    if (line_edge && line_k) begin
                        state <= ln_active;
                    end
                end
                ln_active: begin
                    if (sample) begin
                        if (se0) begin
                            eop   <= 1'b1;
                            state <= ln_wait_j;
                        end else begin
                            bit_strobe <= 1'b1;
                            line_bit   <= (dp_sync == prev_level);
                            prev_level <= dp_sync;
                        end
                    end
                end
                ln_wait_j: begin
                    if (line_j) begin
                        state <= ln_idle;
                    end
                end
                default: state <= ln_idle;
            endcase
        end
    end

endmodule

// File: logic/usb_packet_fsm.sv
`timescale 1ns/1ps

module usb_packet_fsm (
    input  logic                tb_clk,
    input  logic                tb_n_rst,
    input  logic                byte_strobe,
    input  usb_pkg::byte_t      rx_byte,
    input  logic                byte_pending,
    input  logic                eop,
    input  logic                active,
    input  logic                stuff_error,
    output logic                store,
    output usb_pkg::byte_t      store_data,
    output usb_pkg::rx_packet_t rx_packet,
    output logic                r_error,
    output logic                packet_done,
    output logic                receiving
);
    import usb_pkg::*;

    localparam int cnt_w = 4;

    typedef enum logic [2:0] {
        st_idle,
        st_sync,
        st_pid,
        st_body,
        st_skip
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] byte_cnt;
    byte_t            hold_new;
    byte_t            hold_old;
    logic             pid_ok;
    rx_packet_t       pid_class;
    logic             body_ok;
    logic             hold_full;

    function automatic rx_packet_t classify(input logic [3:0] pid);
        case (pid)
            pid_in:    return pkt_in;
            pid_out:   return pkt_out;
            pid_data0: return pkt_data;
            pid_data1: return pkt_data;
            pid_ack:   return pkt_ack;
            pid_nak:   return pkt_nak;
            default:   return pkt_other;
        endcase
    endfunction

    // check nibble is the complement of the pid
    assign pid_ok    = (rx_byte[7:4] == ~rx_byte[3:0]);
    assign pid_class = classify(rx_byte[3:0]);
    // two newer bytes behind the oldest held one
    assign hold_full = (byte_cnt >= cnt_w'(crc16_bytes));

    // packet complete and clean on a byte boundary
    always_comb begin
        body_ok = 1'b0;
        if (state == st_body && !r_error && !byte_pending && !stuff_error) begin
            case (rx_packet)
                pkt_in, pkt_out: body_ok = (byte_cnt == cnt_w'(token_bytes));
                pkt_data:        body_ok = hold_full;
                default:         body_ok = 1'b0;
            endcase
        end
    end

    // ********************
    // crc holdback
    always_ff @(posedge tb_clk) begin
        if (state == st_body && byte_strobe) begin
            hold_old   <= hold_new;
            hold_new   <= rx_byte;
            store_data <= hold_old;
        end
    end

    // ********************
    // packet sequencing and status
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            state       <= st_idle;
            byte_cnt    <= '0;
            store       <= 1'b0;
            rx_packet   <= pkt_none;
            r_error     <= 1'b0;
            packet_done <= 1'b0;
            receiving   <= 1'b0;
        end else begin
            store <= 1'b0;
            if (receiving && stuff_error) begin
                r_error <= 1'b1;
            end
            if (state != st_idle && eop) begin
                state       <= st_idle;
                receiving   <= 1'b0;
                packet_done <= body_ok;
                // truncated header or partial byte
                if (byte_pending || stuff_error || state == st_sync || state == st_pid) begin
                    r_error <= 1'b1;
                end
            end else begin
                case (state)
                    st_idle: begin
                        if (active) begin
                            state       <= st_sync;
                            receiving   <= 1'b1;
                            byte_cnt    <= '0;
                            rx_packet   <= pkt_none;
                            r_error     <= 1'b0;
                            packet_done <= 1'b0;
                        end
                    end
                    st_sync: begin
                        if (byte_strobe) begin
                            if (rx_byte == sync_byte) begin
                                state <= st_pid;
                            end else begin
                                r_error <= 1'b1;
                                state   <= st_skip;
                            end
                        end
                    end
                    st_pid: begin
                        if (byte_strobe) begin
                            if (!pid_ok) begin
                                r_error <= 1'b1;
                                state   <= st_skip;
                            end else begin
                                rx_packet <= pid_class;
                                if (pid_class == pkt_in || pid_class == pkt_out ||
                                    pid_class == pkt_data) begin
                                    state <= st_body;
                                end else begin
                                    state <= st_skip;
                                end
                            end
                        end
                    end
                    st_body: begin
                        if (byte_strobe) begin
                            if (byte_cnt != '1) begin
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                            store <= (rx_packet == pkt_data) && hold_full;
                        end
                    end
                    default: begin
                        // ignore the rest until eop
                    end
                endcase
            end
        end
    end

endmodule

// File: logic/usb_pkg.sv
package usb_pkg;

    // one byte on the bus
    typedef logic [7:0] byte_t;

    // packet class reported to the host side
    typedef enum logic [2:0] {
        pkt_none  = 3'd0,
        pkt_in    = 3'd1,
        pkt_out   = 3'd2,
        pkt_data  = 3'd3,
        pkt_ack   = 3'd4,
        pkt_nak   = 3'd5,
        pkt_other = 3'd6
    } rx_packet_t;

    // sync pattern as assembled lsb first
    localparam byte_t sync_byte = 8'h80;

    // pid low nibbles
    localparam logic [3:0] pid_out   = 4'b0001;
    localparam logic [3:0] pid_in    = 4'b1001;
    localparam logic [3:0] pid_data0 = 4'b0011;
    localparam logic [3:0] pid_data1 = 4'b1011;
    localparam logic [3:0] pid_ack   = 4'b0010;
    localparam logic [3:0] pid_nak   = 4'b1010;

    // framing
    localparam int stuff_limit = 6;
    localparam int token_bytes = 2;
    localparam int crc16_bytes = 2;

endpackage

// File: logic/usb_rx.sv
`timescale 1ns/1ps

module usb_rx (
    input  logic                tb_clk,
    input  logic                tb_n_rst,
    input  logic                d_plus,
    input  logic                d_minus,
    input  logic                r_enable,
    output usb_pkg::byte_t      rx_packet_data,
    output usb_pkg::rx_packet_t rx_packet,
    output logic                r_error,
    output logic                packet_done,
    output logic                receiving,
    output logic                empty,
    output logic                full
);
    import usb_pkg::*;

    // line level
    logic  line_strobe;
    logic  line_bit;
    logic  line_eop;
    logic  line_active;
    // after unstuffing
    logic  data_strobe;
    logic  data_bit;
    logic  stuff_error;
    logic  eop;
    logic  active;
    // bytes and payload writes
    logic  byte_strobe;
    logic  byte_pending;
    byte_t rx_byte;
    logic  store;
    byte_t store_data;

    // ********************
    // serial receive chain
    usb_line_sync u_line_sync (
        .tb_clk     (tb_clk),
        .tb_n_rst   (tb_n_rst),
        .d_plus     (d_plus),
        .d_minus    (d_minus),
        .bit_strobe (line_strobe),
        .line_bit   (line_bit),
        .eop        (line_eop),
        .active     (line_active)
    );

    usb_bit_unstuff u_bit_unstuff (
        .tb_clk      (tb_clk),
        .tb_n_rst    (tb_n_rst),
        .bit_strobe  (line_strobe),
        .line_bit    (line_bit),
        .eop         (line_eop),
        .active      (line_active),
        .data_strobe (data_strobe),
        .data_bit    (data_bit),
        .stuff_error (stuff_error),
        .eop_out     (eop),
        .active_out  (active)
    );

    usb_byte_shift u_byte_shift (
        .tb_clk       (tb_clk),
        .tb_n_rst     (tb_n_rst),
        .data_strobe  (data_strobe),
        .data_bit     (data_bit),
        .active       (active),
        .byte_strobe  (byte_strobe),
        .rx_byte      (rx_byte),
        .byte_pending (byte_pending)
    );

    usb_packet_fsm u_packet_fsm (
        .tb_clk       (tb_clk),
        .tb_n_rst     (tb_n_rst),
        .byte_strobe  (byte_strobe),
        .rx_byte      (rx_byte),
        .byte_pending (byte_pending),
        .eop          (eop),
        .active       (active),
        .stuff_error  (stuff_error),
        .store        (store),
        .store_data   (store_data),
        .rx_packet    (rx_packet),
        .r_error      (r_error),
        .packet_done  (packet_done),
        .receiving    (receiving)
    );

    // ********************
    // payload buffer
    rx_fifo u_rx_fifo (
        .tb_clk     (tb_clk),
        .tb_n_rst   (tb_n_rst),
        .store      (store),
        .store_data (store_data),
        .r_enable   (r_enable),
        .r_data     (rx_packet_data),
        .empty      (empty),
        .full       (full)
    );

endmodule

// File: sim/tb_usb_rx.sv
`timescale 1ns/1ps

module tb_usb_rx;
    import usb_pkg::*;
    import rx_pkg::*;

    localparam int n_rows      = 15;
    localparam int max_body    = 12;
    localparam int cycle_limit = n_rows * 16 * 8 * bit_clks + 4096;

    // one packet per row, body byte 0 in the low bits
    typedef struct packed {
        byte_t       sync;
        byte_t       pid;
        logic [95:0] body;
        int          n_body;
        int          n_extra;
        logic        rnd;
        logic        bad_stuff;
        rx_packet_t  exp_pkt;
        logic        exp_err;
        logic        exp_done;
        int          exp_stored;
    } row_t;

    logic        tb_clk;
    logic        tb_n_rst;
    logic        d_plus;
    logic        d_minus;
    logic        r_enable;
    byte_t       rx_packet_data;
    rx_packet_t  rx_packet;
    logic        r_error;
    logic        packet_done;
    logic        receiving;
    logic        empty;
    logic        full;

    row_t        rows [n_rows];
    byte_t       payload [max_body];
    logic        line_q [$];
    byte_t       expect_q [$];
    logic [15:0] lfsr_state;
    int          cycle_count = 0;

    usb_rx UUT (
        .tb_clk         (tb_clk),
        .tb_n_rst       (tb_n_rst),
        .d_plus         (d_plus),
        .d_minus        (d_minus),
        .r_enable       (r_enable),
        .rx_packet_data (rx_packet_data),
        .rx_packet      (rx_packet),
        .r_error        (r_error),
        .packet_done    (packet_done),
        .receiving      (receiving),
        .empty          (empty),
        .full           (full)
    );

    initial begin
        tb_clk = 1'b0;
        forever #2 tb_clk = ~tb_clk;
    end

    // ********************
    // failure handling

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        abort_run();
    endtask

    always @(posedge tb_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the receiver did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // ********************
    // stimulus table

    task automatic load_table();
        // sync, pid, body, bytes, extra bits, random, no stuffing,
        // expected packet, error, done, stored bytes
        rows[0]  = '{8'h80, 8'h69, 96'h2a15, 2, 0, 1'b0, 1'b0, pkt_in, 1'b0, 1'b1, 0};
        rows[1]  = '{8'h80, 8'he1, 96'h0c3b, 2, 0, 1'b0, 1'b0, pkt_out, 1'b0, 1'b1, 0};
        rows[2]  = '{8'h80, 8'hd2, 96'h0, 0, 0, 1'b0, 1'b0, pkt_ack, 1'b0, 1'b0, 0};
        rows[3]  = '{8'h80, 8'h5a, 96'h0, 0, 0, 1'b0, 1'b0, pkt_nak, 1'b0, 1'b0, 0};
        // setup pid, valid check nibble but not decoded
        rows[4]  = '{8'h80, 8'h2d, 96'h1005, 2, 0, 1'b0, 1'b0, pkt_other, 1'b0, 1'b0, 0};
        rows[5]  = '{8'h80, 8'hc3, 96'h8967452301, 5, 0, 1'b0, 1'b0, pkt_data, 1'b0, 1'b1, 3};
        rows[6]  = '{8'h80, 8'h4b, 96'h0, 7, 0, 1'b1, 1'b0, pkt_data, 1'b0, 1'b1, 5};
        // long runs of ones force stuffing
        rows[7]  = '{8'h80, 8'hc3, 96'hffffffffffff, 6, 0, 1'b0, 1'b0, pkt_data, 1'b0, 1'b1, 4};
        rows[8]  = '{8'h80, 8'h4b, 96'h0, 4, 0, 1'b1, 1'b0, pkt_data, 1'b0, 1'b1, 2};
        rows[9]  = '{8'h80, 8'hc3, 96'hbeef, 2, 0, 1'b0, 1'b0, pkt_data, 1'b0, 1'b1, 0};
        // error cases
        rows[10] = '{8'h84, 8'hc3, 96'h3344, 2, 0, 1'b0, 1'b0, pkt_none, 1'b1, 1'b0, 0};
        rows[11] = '{8'h80, 8'h79, 96'h2a15, 2, 0, 1'b0, 1'b0, pkt_none, 1'b1, 1'b0, 0};
        rows[12] = '{8'h80, 8'hc3, 96'h5544332211, 5, 3, 1'b0, 1'b0, pkt_data, 1'b1, 1'b0, 3};
        rows[13] = '{8'h80, 8'he1, 96'hffff, 2, 0, 1'b0, 1'b1, pkt_out, 1'b1, 1'b0, 0};
        // overflows the payload buffer
        rows[14] = '{8'h80, 8'h4b, 96'h0, 12, 0, 1'b1, 1'b0, pkt_data, 1'b0, 1'b1, 10};
    endtask

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    task automatic draw_random_byte(output byte_t b);
        for (int k = 0; k < 8; k++) begin
            b[k]       = lfsr_state[0];
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    task automatic fill_payload(input row_t r);
        for (int i = 0; i < max_body; i++) begin
            if (i >= r.n_body) begin
                payload[i] = 8'h00;
            end else if (r.rnd) begin
                draw_random_byte(payload[i]);
            end else begin
                payload[i] = r.body[8*i +: 8];
            end
        end
    endtask

    // ********************
    // host line model

    task automatic build_line_bits(input row_t r);
        logic raw_q [$];
        int   ones;
        raw_q  = {};
        line_q = {};
        for (int k = 0; k < 8; k++) begin
            raw_q.push_back(r.sync[k]);
        end
        for (int k = 0; k < 8; k++) begin
            raw_q.push_back(r.pid[k]);
        end
        for (int i = 0; i < r.n_body; i++) begin
            for (int k = 0; k < 8; k++) begin
                raw_q.push_back(payload[i][k]);
            end
        end
        for (int i = 0; i < r.n_extra; i++) begin
            raw_q.push_back(1'b0);
        end
        // stuffed zero after six ones in a row
        ones = 0;
        foreach (raw_q[i]) begin
            line_q.push_back(raw_q[i]);
            ones = raw_q[i] ? ones + 1 : 0;
            if (ones == stuff_limit && !r.bad_stuff) begin
                line_q.push_back(1'b0);
                ones = 0;
            end
        end
    endtask

    task automatic send_packet(input int idx);
        logic level;
        level = 1'b1;
        foreach (line_q[i]) begin
            // nrzi, a zero toggles the line
            if (!line_q[i]) begin
                level = !level;
            end
            d_plus  = level;
            d_minus = !level;
            repeat (bit_clks) @(negedge tb_clk);
            if (i == 7) begin
                assert (receiving)
                else report_mismatch($sformatf("row %0d: receiving low after sync", idx));
            end
        end
        // eop is two bits of se0, then back to J
        d_plus  = 1'b0;
        d_minus = 1'b0;
        repeat (2 * bit_clks) @(negedge tb_clk);
        d_plus  = 1'b1;
        d_minus = 1'b0;
        while (receiving) begin
            @(negedge tb_clk);
        end
        repeat (2 * bit_clks) @(negedge tb_clk);
    endtask

    task automatic build_expected(input row_t r);
        expect_q = {};
        for (int i = 0; i < r.exp_stored && i < fifo_depth; i++) begin
            expect_q.push_back(payload[i]);
        end
    endtask

    // ********************
    // output checks

    task automatic check_reset_state();
        assert (rx_packet == pkt_none)
        else report_mismatch($sformatf("rx_packet %0d after reset", rx_packet));
        assert (!r_error) else report_mismatch("r_error high after reset");
        assert (!packet_done) else report_mismatch("packet_done high after reset");
        assert (!receiving) else report_mismatch("receiving high after reset");
        assert (empty) else report_mismatch("empty low after reset");
        assert (!full) else report_mismatch("full high after reset");
    endtask

    task automatic check_status(input int idx, input row_t r);
        assert (rx_packet == r.exp_pkt)
        else report_mismatch($sformatf("row %0d: rx_packet %0d, expected %0d",
                                       idx, rx_packet, r.exp_pkt));
        assert (r_error == r.exp_err)
        else report_mismatch($sformatf("row %0d: r_error %0b, expected %0b",
                                       idx, r_error, r.exp_err));
        assert (packet_done == r.exp_done)
        else report_mismatch($sformatf("row %0d: packet_done %0b, expected %0b",
                                       idx, packet_done, r.exp_done));
        assert (full == (r.exp_stored >= fifo_depth))
        else report_mismatch($sformatf("row %0d: full %0b with %0d bytes stored",
                                       idx, full, r.exp_stored));
    endtask

    task automatic drain_fifo(input int idx);
        foreach (expect_q[i]) begin
            assert (!empty)
            else report_mismatch($sformatf("row %0d: empty before byte %0d", idx, i));
            assert (rx_packet_data == expect_q[i])
            else report_mismatch($sformatf("row %0d: byte %0d is %02h, expected %02h",
                                           idx, i, rx_packet_data, expect_q[i]));
            r_enable = 1'b1;
            @(negedge tb_clk);
            r_enable = 1'b0;
        end
        assert (empty)
        else report_mismatch($sformatf("row %0d: bytes left after the payload", idx));
        assert (!full)
        else report_mismatch($sformatf("row %0d: full high after draining", idx));
    endtask

    // ********************
    // main sequence

    initial begin
        tb_n_rst   = 1'b0;
        d_plus     = 1'b1;
        d_minus    = 1'b0;
        r_enable   = 1'b0;
        lfsr_state = 16'd1505;
        load_table();
        repeat (16) @(negedge tb_clk);
        tb_n_rst = 1'b1;
        @(negedge tb_clk);
        check_reset_state();
        for (int idx = 0; idx < n_rows; idx++) begin
            fill_payload(rows[idx]);
            build_line_bits(rows[idx]);
            build_expected(rows[idx]);
            send_packet(idx);
            check_status(idx, rows[idx]);
            drain_fifo(idx);
        end
        $display("all tests passed");
        $finish;
    end

endmodule
